/* hw/core_settings.svh */
// Core-wide width macros and reset vector

`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

//////////////////////////////
// Datapath
//////////////////////////////

// Data and address width
`define CORE_DW 32

// Register address width, 32 registers
`define CORE_RAW 5

//////////////////////////////
// Fetch
//////////////////////////////

// First instruction address after reset
`define CORE_RST_VECTOR 32'h0000_0000

`endif

/* hw/isa_pkg.sv */
// Instruction set encoding: opcode numbering, instruction formats
// and the class of the 16-bit immediate

`include "core_settings.svh"

package isa_pkg;

   // Opcodes of the kept instructions, anything else decodes as a no-op
   typedef enum logic [5:0] {
      op_and  = 6'h01,
      op_andi = 6'h02,
      op_or   = 6'h03,
      op_ori  = 6'h04,
      op_xor  = 6'h05,
      op_xori = 6'h06,
      op_lsl  = 6'h07,
      op_lsli = 6'h08,
      op_lsr  = 6'h09,
      op_lsri = 6'h0A,
      op_asr  = 6'h0B,
      op_asri = 6'h0C,
      op_add  = 6'h0D,
      op_addi = 6'h0E,
      op_sub  = 6'h0F,
      op_ldw  = 6'h10,  // Word load
      op_stw  = 6'h11,  // Word store, data register in rd
      op_jmpi = 6'h12   // PC-relative jump and link
   } opcode_e;

   // Register form
   typedef struct packed {
      logic [10:0]          attr;
      logic [`CORE_RAW-1:0] rs2;
      logic [`CORE_RAW-1:0] rs1;
      logic [`CORE_RAW-1:0] rd;
      logic [5:0]           opcode;
   } insn_r_t;

   // Immediate form, bits 31..11 double as the jump offset
   typedef struct packed {
      logic [15:0]          imm16;
      logic [`CORE_RAW-1:0] rs1;
      logic [`CORE_RAW-1:0] rd;
      logic [5:0]           opcode;
   } insn_i_t;

   typedef union packed {
      insn_r_t r;
      insn_i_t i;
   } insn_u;

   typedef enum logic [1:0] {
      imm_none     = 2'd0,  // Operand 2 comes from rs2
      imm_signed   = 2'd1,
      imm_unsigned = 2'd2
   } imm_kind_e;

endpackage

/* hw/core_pkg.sv */
// Pipeline bundles between stages and the data bus request

`include "core_settings.svh"

package core_pkg;

   // One-hot select of the shift/logic unit
   typedef struct packed {
      logic is_and;
      logic is_or;
      logic is_xor;
      logic is_lsl;
      logic is_lsr;
      logic is_asr;
   } lu_op_t;

   // Decode to execute
   typedef struct packed {
      logic                 valid;
      lu_op_t               lu_op;
      logic                 add;
      logic                 sub;
      logic                 load;
      logic                 store;
      logic                 link;       // Result is the link address
      logic [`CORE_DW-1:0]  link_addr;  // Jump PC plus 8
      logic                 wb_en;
      logic [`CORE_RAW-1:0] rd;
      isa_pkg::imm_kind_e   imm_kind;
      logic [15:0]          imm16;
   } ex_bundle_t;

   typedef struct packed {
      logic                rd;
      logic                we;
      logic [`CORE_DW-1:0] addr;
      logic [`CORE_DW-1:0] wdata;
   } dbus_req_t;

endpackage

/* hw/fetch_unit.sv */
`timescale 1ns/1ps
// Fetch stage: program counter, instruction bus address and
// the fetch to decode register

`include "core_settings.svh"

module fetch_unit (
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic [31:0]         insn_i,
   input  logic                insn_ready_i,
   input  logic                exec_ready_i,
   input  logic                jmp_i,
   input  logic [`CORE_DW-1:0] jmp_target_i,
   output logic [`CORE_DW-1:0] iaddr_o,
   output logic                ibus_rd_o,
   output isa_pkg::insn_u      dec_insn_o,
   output logic [`CORE_DW-1:0] dec_pc_o,
   output logic                dec_valid_o
);
   localparam logic [`CORE_DW-1:0] word_step = 4;

   logic [`CORE_DW-1:0] pc_q;        // Address of the word now on insn_i
   logic                req_q;       // Clear only in the first cycle after reset
   logic                redir_q;     // Jump left decode while fetch stalled
   logic [`CORE_DW-1:0] redir_pc_q;
   logic                fetch_adv;
   logic [`CORE_DW-1:0] pc_nxt;

   assign fetch_adv = req_q & insn_ready_i & exec_ready_i;
   assign ibus_rd_o = 1'b1;

   always_comb begin
      if (jmp_i)
         pc_nxt = jmp_target_i;
      else if (redir_q)
         pc_nxt = redir_pc_q;
      else
         pc_nxt = pc_q + word_step;
   end

   // Re-request the pending word until it is taken
   assign iaddr_o = fetch_adv ? pc_nxt : pc_q;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         pc_q        <= `CORE_RST_VECTOR;
         req_q       <= 1'b0;
         redir_q     <= 1'b0;
         dec_valid_o <= 1'b0;
      end else begin
         pc_q  <= iaddr_o;
         req_q <= 1'b1;
         if (fetch_adv)
            redir_q <= 1'b0;
         else if (jmp_i & exec_ready_i)
            redir_q <= 1'b1;
         if (exec_ready_i)
            dec_valid_o <= fetch_adv;  // Bubble when the word is not ready
      end
   end

   always_ff @(posedge clk_i) begin
      if (jmp_i & exec_ready_i & ~fetch_adv)
         redir_pc_q <= jmp_target_i;
      if (fetch_adv) begin
         dec_insn_o <= insn_i;
         dec_pc_o   <= pc_q;
      end
   end

endmodule

/* hw/decode_unit.sv */
`timescale 1ns/1ps
// Decode stage: unit selects, immediate class, register read addresses,
// JMPI redirect and the decode to execute register

`include "core_settings.svh"

module decode_unit (
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  isa_pkg::insn_u       dec_insn_i,
   input  logic [`CORE_DW-1:0]  dec_pc_i,
   input  logic                 dec_valid_i,
   input  logic                 exec_ready_i,
   output logic [`CORE_RAW-1:0] rs1_addr_o,
   output logic [`CORE_RAW-1:0] rs2_addr_o,
   output logic                 jmp_o,
   output logic [`CORE_DW-1:0]  jmp_target_o,
   output core_pkg::ex_bundle_t ex_bundle_o
);
   localparam logic [`CORE_DW-1:0] link_step = 8;  // Skips the delay slot

   logic [5:0]           opc;
   logic [20:0]          rel21;
   logic                 is_store;
   core_pkg::ex_bundle_t ex_nxt;

   assign opc      = dec_insn_i.r.opcode;
   assign rel21    = dec_insn_i.i[31:11];  // Jump offset in words
   assign is_store = (opc == isa_pkg::op_stw);

   //////////////////////////////
   // Register reads and jump
   //////////////////////////////

   assign rs1_addr_o = dec_insn_i.r.rs1;
   assign rs2_addr_o = is_store ? dec_insn_i.r.rd : dec_insn_i.r.rs2;  // Store data

   assign jmp_o        = dec_valid_i & (opc == isa_pkg::op_jmpi);
   assign jmp_target_o = dec_pc_i + {{(`CORE_DW-23){rel21[20]}}, rel21, 2'b00};

   //////////////////////////////
   // Bundle decode
   //////////////////////////////

   always_comb begin
      ex_nxt           = '0;
      ex_nxt.valid     = dec_valid_i;
      ex_nxt.rd        = dec_insn_i.r.rd;
      ex_nxt.imm16     = dec_insn_i.i.imm16;
      ex_nxt.link_addr = dec_pc_i + link_step;
      case (opc)
         isa_pkg::op_and:  ex_nxt.lu_op.is_and = 1'b1;
         isa_pkg::op_or:   ex_nxt.lu_op.is_or  = 1'b1;
         isa_pkg::op_xor:  ex_nxt.lu_op.is_xor = 1'b1;
         isa_pkg::op_lsl:  ex_nxt.lu_op.is_lsl = 1'b1;
         isa_pkg::op_lsr:  ex_nxt.lu_op.is_lsr = 1'b1;
         isa_pkg::op_asr:  ex_nxt.lu_op.is_asr = 1'b1;
         isa_pkg::op_add:  ex_nxt.add = 1'b1;
         isa_pkg::op_sub:  ex_nxt.sub = 1'b1;
         isa_pkg::op_jmpi: ex_nxt.link = 1'b1;
         isa_pkg::op_andi: begin
            ex_nxt.lu_op.is_and = 1'b1;
            ex_nxt.imm_kind     = isa_pkg::imm_signed;
         end
         isa_pkg::op_ori: begin
            ex_nxt.lu_op.is_or = 1'b1;
            ex_nxt.imm_kind    = isa_pkg::imm_unsigned;
         end
         isa_pkg::op_xori: begin
            ex_nxt.lu_op.is_xor = 1'b1;
            ex_nxt.imm_kind     = isa_pkg::imm_signed;
         end
         isa_pkg::op_lsli: begin
            ex_nxt.lu_op.is_lsl = 1'b1;
            ex_nxt.imm_kind     = isa_pkg::imm_unsigned;
         end
         isa_pkg::op_lsri: begin
            ex_nxt.lu_op.is_lsr = 1'b1;
            ex_nxt.imm_kind     = isa_pkg::imm_unsigned;
         end
         isa_pkg::op_asri: begin
            ex_nxt.lu_op.is_asr = 1'b1;
            ex_nxt.imm_kind     = isa_pkg::imm_unsigned;
         end
         isa_pkg::op_addi: begin
            ex_nxt.add      = 1'b1;
            ex_nxt.imm_kind = isa_pkg::imm_signed;
         end
         isa_pkg::op_ldw: begin
            ex_nxt.load     = 1'b1;
            ex_nxt.imm_kind = isa_pkg::imm_signed;  // Address offset
         end
         isa_pkg::op_stw: begin
            ex_nxt.store    = 1'b1;
            ex_nxt.imm_kind = isa_pkg::imm_signed;
         end
         default: ;  // No-op
      endcase
      // r0 is never written
      ex_nxt.wb_en = ((|ex_nxt.lu_op) | ex_nxt.add | ex_nxt.sub | ex_nxt.load | ex_nxt.link)
                     & (ex_nxt.rd != '0);
   end

   always_ff @(posedge clk_i) begin
      if (rst_i)
         ex_bundle_o <= '0;
      else if (exec_ready_i)
         ex_bundle_o <= ex_nxt;
   end

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ps
// Register file, 32 words with r0 tied to zero
// Registered read ports with write-first bypass

`include "core_settings.svh"

module reg_file (
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  logic                 advance_i,
   input  logic [`CORE_RAW-1:0] rs1_addr_i,
   input  logic [`CORE_RAW-1:0] rs2_addr_i,
   input  logic                 wr_en_i,
   input  logic [`CORE_RAW-1:0] wr_addr_i,
   input  logic [`CORE_DW-1:0]  wr_data_i,
   output logic [`CORE_DW-1:0]  rs1_data_o,
   output logic [`CORE_DW-1:0]  rs2_data_o
);
   logic [`CORE_DW-1:0] regs [2**`CORE_RAW];

   // Same-cycle write wins over the stored word
   function automatic logic [`CORE_DW-1:0] read_port(input logic [`CORE_RAW-1:0] addr);
      if (addr == '0)
         return '0;
      else if (wr_en_i && (addr == wr_addr_i))
         return wr_data_i;
      else
         return regs[addr];
   endfunction

   always_ff @(posedge clk_i) begin
      if (wr_en_i && (wr_addr_i != '0))
         regs[wr_addr_i] <= wr_data_i;
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rs1_data_o <= '0;
         rs2_data_o <= '0;
      end else if (advance_i) begin
         rs1_data_o <= read_port(rs1_addr_i);
         rs2_data_o <= read_port(rs2_addr_i);
      end
   end

endmodule

/* hw/shift_logic_unit.sv */
`timescale 1ns/1ps
// AND/OR/XOR and the shared right shifter for LSL, LSR and ASR

`include "core_settings.svh"

module shift_logic_unit (
   input  core_pkg::lu_op_t    op_i,
   input  logic [`CORE_DW-1:0] a_i,
   input  logic [`CORE_DW-1:0] b_i,
   output logic [`CORE_DW-1:0] result_o
);
   logic [`CORE_DW-1:0]   shift_in;
   logic [`CORE_DW-1:0]   shift_fill;
   logic [2*`CORE_DW-1:0] shift_wide;
   logic [`CORE_DW-1:0]   shifted;
   logic [`CORE_DW-1:0]   shift_res;
   logic                  is_shift;

   function automatic logic [`CORE_DW-1:0] bit_rev(input logic [`CORE_DW-1:0] v);
      logic [`CORE_DW-1:0] r;
      for (int k = 0; k < `CORE_DW; k++) begin
         r[`CORE_DW-1-k] = v[k];
      end
      return r;
   endfunction

   // Left shift is a right shift of the mirrored word
   assign shift_in   = op_i.is_lsl ? bit_rev(a_i) : a_i;
   assign shift_fill = op_i.is_asr ? {`CORE_DW{a_i[`CORE_DW-1]}} : '0;
   assign shift_wide = {shift_fill, shift_in} >> b_i[4:0];
   assign shifted    = shift_wide[`CORE_DW-1:0];
   assign shift_res  = op_i.is_lsl ? bit_rev(shifted) : shifted;
   assign is_shift   = op_i.is_lsl | op_i.is_lsr | op_i.is_asr;

   // Zero when no unit is selected
   assign result_o = ({`CORE_DW{op_i.is_and}} & (a_i & b_i)) |
                     ({`CORE_DW{op_i.is_or}}  & (a_i | b_i)) |
                     ({`CORE_DW{op_i.is_xor}} & (a_i ^ b_i)) |
                     ({`CORE_DW{is_shift}}    & shift_res);

endmodule

/* hw/exec_unit.sv */
`timescale 1ns/1ps
// Execute stage: operand select, add/sub adder, data bus access,
// result select and register write-back

`include "core_settings.svh"

module exec_unit (
   input  core_pkg::ex_bundle_t ex_bundle_i,
   input  logic [`CORE_DW-1:0]  rs1_data_i,
   input  logic [`CORE_DW-1:0]  rs2_data_i,
   input  logic [`CORE_DW-1:0]  d_i,
   input  logic                 dbus_rd_ready_i,
   input  logic                 dbus_we_done_i,
   output core_pkg::dbus_req_t  dbus_req_o,
   output logic                 exec_rdy_o,
   output logic                 wr_en_o,
   output logic [`CORE_RAW-1:0] wr_addr_o,
   output logic [`CORE_DW-1:0]  wr_data_o
);
   logic [`CORE_DW-1:0] imm_ext;
   logic [`CORE_DW-1:0] opnd2;
   logic [`CORE_DW-1:0] add_b;
   logic [`CORE_DW-1:0] sum;
   logic [`CORE_DW-1:0] lu_res;
   logic                do_load;
   logic                do_store;

   //////////////////////////////
   // Operands and adder
   //////////////////////////////

   always_comb begin
      case (ex_bundle_i.imm_kind)
         isa_pkg::imm_signed:   imm_ext = {{(`CORE_DW-16){ex_bundle_i.imm16[15]}},
                                           ex_bundle_i.imm16};
         isa_pkg::imm_unsigned: imm_ext = {{(`CORE_DW-16){1'b0}}, ex_bundle_i.imm16};
         default:               imm_ext = '0;
      endcase
   end

   assign opnd2 = (ex_bundle_i.imm_kind == isa_pkg::imm_none) ? rs2_data_i : imm_ext;
   assign add_b = ex_bundle_i.sub ? ~opnd2 : opnd2;
   assign sum   = rs1_data_i + add_b + {{(`CORE_DW-1){1'b0}}, ex_bundle_i.sub};

   shift_logic_unit slu_inst (
      .op_i     (ex_bundle_i.lu_op),
      .a_i      (rs1_data_i),
      .b_i      (opnd2),
      .result_o (lu_res)
   );

   //////////////////////////////
   // Data bus
   //////////////////////////////

   assign do_load  = ex_bundle_i.valid & ex_bundle_i.load;
   assign do_store = ex_bundle_i.valid & ex_bundle_i.store;

   assign dbus_req_o.rd    = do_load;
   assign dbus_req_o.we    = do_store;
   assign dbus_req_o.addr  = sum;         // rs1 plus signed offset
   assign dbus_req_o.wdata = rs2_data_i;  // Register named by rd

   // Whole pipeline waits on the bus
   assign exec_rdy_o = ~(do_load & ~dbus_rd_ready_i) & ~(do_store & ~dbus_we_done_i);

   // Write-back
   assign wr_en_o   = ex_bundle_i.valid & ex_bundle_i.wb_en & exec_rdy_o;
   assign wr_addr_o = ex_bundle_i.rd;
   assign wr_data_o = lu_res |
                      ({`CORE_DW{ex_bundle_i.add | ex_bundle_i.sub}} & sum) |
                      ({`CORE_DW{ex_bundle_i.load}} & d_i) |
                      ({`CORE_DW{ex_bundle_i.link}} & ex_bundle_i.link_addr);

endmodule

/* hw/core_top.sv */
`timescale 1ns/1ps
// Core top level: fetch, decode, register file and execute

`include "core_settings.svh"

module core_top (
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic [31:0]         insn_i,
   input  logic                insn_ready_i,
   output logic [`CORE_DW-1:0] iaddr_o,
   output logic                ibus_rd_o,
   input  logic [`CORE_DW-1:0] d_i,
   input  logic                dbus_rd_ready_i,
   input  logic                dbus_we_done_i,
   output logic [`CORE_DW-1:0] d_o,
   output logic [`CORE_DW-1:0] addr_o,
   output logic                dbus_rd_o,
   output logic                dbus_we_o
);
   logic                 exec_ready;  // Advances decode and gates fetch
   isa_pkg::insn_u       dec_insn;
   logic [`CORE_DW-1:0]  dec_pc;
   logic                 dec_valid;
   logic [`CORE_RAW-1:0] rs1_addr;
   logic [`CORE_RAW-1:0] rs2_addr;
   logic                 jmp;
   logic [`CORE_DW-1:0]  jmp_target;
   core_pkg::ex_bundle_t ex_bundle;
   logic [`CORE_DW-1:0]  rs1_data;
   logic [`CORE_DW-1:0]  rs2_data;
   core_pkg::dbus_req_t  dbus_req;
   logic                 wr_en;
   logic [`CORE_RAW-1:0] wr_addr;
   logic [`CORE_DW-1:0]  wr_data;

   fetch_unit fetch_inst (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .insn_i       (insn_i),
      .insn_ready_i (insn_ready_i),
      .exec_ready_i (exec_ready),
      .jmp_i        (jmp),
      .jmp_target_i (jmp_target),
      .iaddr_o      (iaddr_o),
      .ibus_rd_o    (ibus_rd_o),
      .dec_insn_o   (dec_insn),
      .dec_pc_o     (dec_pc),
      .dec_valid_o  (dec_valid)
   );

   decode_unit decode_inst (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .dec_insn_i   (dec_insn),
      .dec_pc_i     (dec_pc),
      .dec_valid_i  (dec_valid),
      .exec_ready_i (exec_ready),
      .rs1_addr_o   (rs1_addr),
      .rs2_addr_o   (rs2_addr),
      .jmp_o        (jmp),
      .jmp_target_o (jmp_target),
      .ex_bundle_o  (ex_bundle)
   );

   reg_file reg_file_inst (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .advance_i  (exec_ready),  // Reads captured with the decode advance
      .rs1_addr_i (rs1_addr),
      .rs2_addr_i (rs2_addr),
      .wr_en_i    (wr_en),
      .wr_addr_i  (wr_addr),
      .wr_data_i  (wr_data),
      .rs1_data_o (rs1_data),
      .rs2_data_o (rs2_data)
   );

   exec_unit exec_inst (
      .ex_bundle_i     (ex_bundle),
      .rs1_data_i      (rs1_data),
      .rs2_data_i      (rs2_data),
      .d_i             (d_i),
      .dbus_rd_ready_i (dbus_rd_ready_i),
      .dbus_we_done_i  (dbus_we_done_i),
      .dbus_req_o      (dbus_req),
      .exec_rdy_o      (exec_ready),
      .wr_en_o         (wr_en),
      .wr_addr_o       (wr_addr),
      .wr_data_o       (wr_data)
   );

   // Data bus ports
   assign dbus_rd_o = dbus_req.rd;
   assign dbus_we_o = dbus_req.we;
   assign addr_o    = dbus_req.addr;
   assign d_o       = dbus_req.wdata;

endmodule

/* dv/core_checker.sv */
`timescale 1ns/1ps
// Data bus protocol assertions, bound into the core top level

`include "core_settings.svh"

module core_checker (
   input logic                clk_i,
   input logic                rst_i,
   input logic                rd_i,
   input logic                we_i,
   input logic                rd_ready_i,
   input logic                we_done_i,
   input logic [`CORE_DW-1:0] addr_i,
   input logic [`CORE_DW-1:0] wdata_i
);
   int unsigned assert_fails = 0;

   // One strobe at a time
   strobe_excl: assert property (@(posedge clk_i) disable iff (rst_i) !(rd_i && we_i))
      else begin
         assert_fails++;
         $error("Read and write strobes are high together");
      end

   // A waiting load keeps its request
   load_hold: assert property (@(posedge clk_i) disable iff (rst_i)
         rd_i && !rd_ready_i |=> rd_i && $stable(addr_i))
      else begin
         assert_fails++;
         $error("Load request changed while waiting for ready");
      end

   store_hold: assert property (@(posedge clk_i) disable iff (rst_i)
         we_i && !we_done_i |=> we_i && $stable(addr_i) && $stable(wdata_i))
      else begin
         assert_fails++;
         $error("Store request changed while waiting for done");
      end

endmodule

/* dv/core_monitor.sv */
`timescale 1ns/1ps
// Data bus and instruction bus monitor with the queue of expected stores

`include "core_settings.svh"

module core_monitor (
   input logic                clk_i,
   input logic                rst_i,
   input logic [`CORE_DW-1:0] iaddr_i,
   input logic                ibus_rd_i,
   input logic                dbus_we_i,
   input logic                dbus_we_done_i,
   input logic [`CORE_DW-1:0] addr_i,
   input logic [`CORE_DW-1:0] wdata_i
);
   logic [`CORE_DW-1:0] exp_addr_q [$];
   logic [`CORE_DW-1:0] exp_data_q [$];
   int unsigned         error_count = 0;
   int unsigned         store_count = 0;
   logic                first_fetch = 1'b1;  // Next request is the first after reset

   task automatic clear_expect();
      exp_addr_q.delete();
      exp_data_q.delete();
      store_count = 0;
   endtask

   task automatic expect_store(input logic [`CORE_DW-1:0] a, input logic [`CORE_DW-1:0] d);
      exp_addr_q.push_back(a);
      exp_data_q.push_back(d);
   endtask

   task automatic check_value(input string name, input logic [`CORE_DW-1:0] exp,
                              input logic [`CORE_DW-1:0] act);
      if (act !== exp) begin
         error_count++;
         $display("Fail t=%0t %s expected %h actual %h", $time, name, exp, act);
      end
   endtask

   // Mid-cycle values are the ones the next rising edge sees
   always @(negedge clk_i) begin
      if (rst_i) begin
         first_fetch <= 1'b1;
      end else begin
         check_value("ibus_rd_o", 32'h1, ibus_rd_i);  // Always reading out of reset
         if (first_fetch)
            check_value("iaddr_o", 32'h0000_0000, iaddr_i);
         first_fetch <= 1'b0;
         if (dbus_we_i && dbus_we_done_i) begin  // Store completes on the coming edge
            store_count++;
            if (exp_addr_q.size() == 0) begin
               error_count++;
               $display("Unexpected extra store at time %0t to address %h", $time, addr_i);
            end else begin
               check_value("addr_o", exp_addr_q.pop_front(), addr_i);
               check_value("d_o", exp_data_q.pop_front(), wdata_i);
            end
         end
      end
   end

endmodule

/* dv/core_tb.sv */
`timescale 1ns/1ps
// Core testbench with clock and reset and the program table of expected stores
// Instruction and data memory models with random bus back-pressure

module core_tb;
   localparam int          clk_period     = 20;
   localparam logic [31:0] seed           = 32'd44231;
   localparam logic [31:0] load_mask      = 32'h5A5A_0000;  // Load data is address ^ mask
   localparam int          timeout_cycles = 2000;

   typedef struct packed {
      logic [31:0] insn;
      logic        chk;   // Store that must show on the bus
      logic [31:0] addr;
      logic [31:0] data;
   } prog_row_t;

   logic        clk;
   logic        rst;
   logic [31:0] insn;
   logic        insn_ready;
   logic [31:0] iaddr;
   logic        ibus_rd;
   logic [31:0] d_in;
   logic        dbus_rd_ready;
   logic        dbus_we_done;
   logic [31:0] d_out;
   logic [31:0] addr;
   logic        dbus_rd;
   logic        dbus_we;

   prog_row_t   prog [$];
   logic [31:0] imem [256];
   logic [31:0] fetch_addr;   // Request of the current cycle
   logic        random_mode;
   logic [31:0] rng;
   int unsigned tb_errors;
   logic        timed_out;

   core_top core_top_inst (
      .clk_i           (clk),
      .rst_i           (rst),
      .insn_i          (insn),
      .insn_ready_i    (insn_ready),
      .iaddr_o         (iaddr),
      .ibus_rd_o       (ibus_rd),
      .d_i             (d_in),
      .dbus_rd_ready_i (dbus_rd_ready),
      .dbus_we_done_i  (dbus_we_done),
      .d_o             (d_out),
      .addr_o          (addr),
      .dbus_rd_o       (dbus_rd),
      .dbus_we_o       (dbus_we)
   );

   core_monitor core_monitor_inst (
      .clk_i          (clk),
      .rst_i          (rst),
      .iaddr_i        (iaddr),
      .ibus_rd_i      (ibus_rd),
      .dbus_we_i      (dbus_we),
      .dbus_we_done_i (dbus_we_done),
      .addr_i         (addr),
      .wdata_i        (d_out)
   );

   bind core_top core_checker core_checker_inst (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .rd_i       (dbus_rd_o),
      .we_i       (dbus_we_o),
      .rd_ready_i (dbus_rd_ready_i),
      .we_done_i  (dbus_we_done_i),
      .addr_i     (addr_o),
      .wdata_i    (d_o)
   );

   always #(clk_period / 2) clk = ~clk;

   //////////////////////////////
   // Encoding and program table
   //////////////////////////////

   function automatic logic [31:0] reg_form(input logic [5:0] op, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [4:0] rs2);
      return {11'd0, rs2, rs1, rd, op};
   endfunction

   function automatic logic [31:0] imm_form(input logic [5:0] op, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [15:0] imm);
      return {imm, rs1, rd, op};
   endfunction

   // Offset counts words from the jump
   function automatic logic [31:0] jump_form(input logic [4:0] rd, input logic [20:0] off);
      return {off, rd, isa_pkg::op_jmpi};
   endfunction

   task automatic put_insn(input logic [31:0] w);
      prog.push_back('{w, 1'b0, 32'h0, 32'h0});
   endtask

   task automatic checked_store(input logic [31:0] w, input logic [31:0] a,
                                input logic [31:0] d);
      prog.push_back('{w, 1'b1, a, d});
   endtask

   task automatic build_program();
      // Base r31 = 0x100 with r1 = 0x1234 and r2 = -16
      put_insn(imm_form(isa_pkg::op_ori, 31, 0, 16'h0100));
      put_insn(imm_form(isa_pkg::op_addi, 1, 0, 16'h1234));
      put_insn(imm_form(isa_pkg::op_addi, 2, 0, 16'hFFF0));
      // ANDI and XORI sign-extend while ORI zero-extends
      put_insn(imm_form(isa_pkg::op_andi, 3, 2, 16'h8F0F));
      checked_store(imm_form(isa_pkg::op_stw, 3, 31, 16'h0000), 32'h100, 32'hFFFF_8F00);
      put_insn(imm_form(isa_pkg::op_ori, 4, 1, 16'h8001));
      checked_store(imm_form(isa_pkg::op_stw, 4, 31, 16'h0004), 32'h104, 32'h0000_9235);
      put_insn(imm_form(isa_pkg::op_xori, 5, 1, 16'hFFFF));
      checked_store(imm_form(isa_pkg::op_stw, 5, 31, 16'h0008), 32'h108, 32'hFFFF_EDCB);
      put_insn(reg_form(isa_pkg::op_and, 6, 1, 2));  // 0x1230
      put_insn(reg_form(isa_pkg::op_or, 7, 1, 2));   // 0xFFFFFFF4
      put_insn(reg_form(isa_pkg::op_xor, 8, 6, 7));
      checked_store(imm_form(isa_pkg::op_stw, 8, 31, 16'h000C), 32'h10C, 32'hFFFF_EDC4);
      // Shifts by immediate
      put_insn(imm_form(isa_pkg::op_lsli, 9, 1, 16'h0004));
      put_insn(imm_form(isa_pkg::op_lsri, 10, 2, 16'h0004));
      put_insn(imm_form(isa_pkg::op_asri, 11, 2, 16'h0004));
      checked_store(imm_form(isa_pkg::op_stw, 9, 31, 16'h0010), 32'h110, 32'h0001_2340);
      checked_store(imm_form(isa_pkg::op_stw, 10, 31, 16'h0014), 32'h114, 32'h0FFF_FFFF);
      checked_store(imm_form(isa_pkg::op_stw, 11, 31, 16'h0018), 32'h118, 32'hFFFF_FFFF);
      // Shift amount 0x28 of which only the low 5 bits count
      put_insn(imm_form(isa_pkg::op_addi, 12, 0, 16'h0028));
      put_insn(reg_form(isa_pkg::op_lsl, 13, 1, 12));
      put_insn(reg_form(isa_pkg::op_lsr, 14, 5, 12));
      put_insn(reg_form(isa_pkg::op_asr, 15, 5, 12));
      checked_store(imm_form(isa_pkg::op_stw, 13, 31, 16'h001C), 32'h11C, 32'h0012_3400);
      checked_store(imm_form(isa_pkg::op_stw, 14, 31, 16'h0020), 32'h120, 32'h00FF_FFED);
      checked_store(imm_form(isa_pkg::op_stw, 15, 31, 16'h0024), 32'h124, 32'hFFFF_FFED);
      // Each result feeds the next instruction
      put_insn(reg_form(isa_pkg::op_add, 16, 1, 2));
      put_insn(reg_form(isa_pkg::op_sub, 17, 16, 1));
      put_insn(imm_form(isa_pkg::op_addi, 18, 17, 16'hFF00));
      checked_store(imm_form(isa_pkg::op_stw, 16, 31, 16'h0028), 32'h128, 32'h0000_1224);
      checked_store(imm_form(isa_pkg::op_stw, 17, 31, 16'h002C), 32'h12C, 32'hFFFF_FFF0);
      checked_store(imm_form(isa_pkg::op_stw, 18, 31, 16'h0030), 32'h130, 32'hFFFF_FEF0);
      // Loads from 0x140 and 0xF8
      put_insn(imm_form(isa_pkg::op_ldw, 19, 31, 16'h0040));
      checked_store(imm_form(isa_pkg::op_stw, 19, 31, 16'h0034), 32'h134, 32'h5A5A_0140);
      put_insn(imm_form(isa_pkg::op_ldw, 20, 31, 16'hFFF8));
      checked_store(imm_form(isa_pkg::op_stw, 20, 31, 16'h0038), 32'h138, 32'h5A5A_00F8);
      // Jump at 0x90 to 0xA0 with the delay slot at 0x94
      put_insn(jump_form(21, 21'd4));
      put_insn(imm_form(isa_pkg::op_addi, 22, 0, 16'h0077));
      put_insn(imm_form(isa_pkg::op_stw, 1, 31, 16'h007C));  // Skipped
      put_insn(imm_form(isa_pkg::op_stw, 1, 31, 16'h007C));  // Skipped
      checked_store(imm_form(isa_pkg::op_stw, 21, 31, 16'h003C), 32'h13C, 32'h0000_0098);
      checked_store(imm_form(isa_pkg::op_stw, 22, 31, 16'h0040), 32'h140, 32'h0000_0077);
      // Unknown opcode and a write to r0 change nothing
      put_insn(imm_form(6'h3F, 1, 2, 16'hFFFF));
      put_insn(imm_form(isa_pkg::op_addi, 0, 1, 16'h0005));
      checked_store(imm_form(isa_pkg::op_stw, 1, 31, 16'h0044), 32'h144, 32'h0000_1234);
      checked_store(imm_form(isa_pkg::op_stw, 0, 31, 16'h0048), 32'h148, 32'h0000_0000);
   endtask

   //////////////////////////////
   // Memory models
   //////////////////////////////

   function automatic logic [31:0] next_random(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] fetch_word(input logic [31:0] a);
      if (a[31:10] != '0)
         return '0;  // No-op outside the table
      else
         return imem[a[9:2]];
   endfunction

   always @(negedge clk) fetch_addr <= iaddr;

   // Answers one cycle after the request
   always @(posedge clk) begin
      #1;
      insn <= fetch_word(fetch_addr);
      d_in <= dbus_rd ? (addr ^ load_mask) : '0;  // Data only while a read is requested
      if (random_mode) begin
         rng = next_random(rng);
         insn_ready    <= |rng[1:0];
         dbus_rd_ready <= |rng[3:2];
         dbus_we_done  <= |rng[5:4];
      end else begin
         insn_ready    <= 1'b1;
         dbus_rd_ready <= 1'b1;
         dbus_we_done  <= 1'b1;
      end
   end

   //////////////////////////////
   // Sequence
   //////////////////////////////

   task automatic await_stores(input int unsigned n, output logic expired);
      int unsigned cycles;
      cycles = 0;
      while (core_monitor_inst.store_count < n && cycles < timeout_cycles) begin
         @(negedge clk);
         cycles++;
      end
      expired = (core_monitor_inst.store_count < n);
      if (expired) begin
         tb_errors++;
         $display("Timeout: only %0d of %0d stores seen", core_monitor_inst.store_count, n);
      end
   endtask

   // Runs the fetch past the program so late or repeated stores still show
   task automatic drain_fetch(input logic [31:0] end_addr, output logic expired);
      int unsigned cycles;
      cycles = 0;
      while (iaddr < end_addr && cycles < timeout_cycles) begin
         @(negedge clk);
         cycles++;
      end
      expired = (iaddr < end_addr);
      if (expired) begin
         tb_errors++;
         $display("Timeout: instruction fetch never reached address %h", end_addr);
      end
   endtask

   initial begin
      int unsigned n_exp;
      int unsigned total;
      clk           = 1'b0;
      rst           = 1'b1;
      insn          = '0;
      insn_ready    = 1'b0;
      d_in          = '0;
      dbus_rd_ready = 1'b0;
      dbus_we_done  = 1'b0;
      fetch_addr    = '0;
      random_mode   = 1'b0;
      rng           = seed;
      tb_errors     = 0;
      timed_out     = 1'b0;
      n_exp         = 0;
      build_program();
      for (int i = 0; i < 256; i++) begin
         imem[i] = '0;
      end
      foreach (prog[i]) begin
         imem[i] = prog[i].insn;
         if (prog[i].chk)
            n_exp++;
      end
      // Directed pass and then the same program under random back-pressure
      for (int phase = 0; phase < 2 && !timed_out; phase++) begin
         rst = 1'b1;
         core_monitor_inst.clear_expect();
         foreach (prog[i]) begin
            if (prog[i].chk)
               core_monitor_inst.expect_store(prog[i].addr, prog[i].data);
         end
         repeat (4) @(posedge clk);
         #1;
         rst = 1'b0;
         await_stores(n_exp, timed_out);
         if (!timed_out)
            drain_fetch(32'h0000_0100, timed_out);
         random_mode = 1'b1;
         @(posedge clk);
         #1;
      end
      total = core_monitor_inst.error_count + core_top_inst.core_checker_inst.assert_fails +
              tb_errors;
      $display("Errors: monitor %0d, checker %0d, testbench %0d",
               core_monitor_inst.error_count, core_top_inst.core_checker_inst.assert_fails,
               tb_errors);
      if (total == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

/* tb.f */
+incdir+hw
hw/isa_pkg.sv
hw/core_pkg.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/reg_file.sv
hw/shift_logic_unit.sv
hw/exec_unit.sv
hw/core_top.sv
dv/core_checker.sv
dv/core_monitor.sv
dv/core_tb.sv
